// File: filelist.f
src/sweepAcqPkg.sv
src/dacStepper.sv
src/packageCounter.sv
src/sweepDataPath.sv
src/sweepControl.sv
src/sweepAcqTop.sv
sim/tbClock.sv
sim/frontEndModel.sv
sim/sweepAcqTb.sv

// File: run.sh
#!/bin/sh
# Build the sweep testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module sweepAcqTb -f filelist.f \
  --Mdir obj_dir -o sweepAcqSim &&
./obj_dir/sweepAcqSim &&
echo "Simulation finished without errors" ||
{ echo "Build or simulation failed"; exit 1; }

// File: sim/frontEndModel.sv
`timescale 1ns/1ns

module frontEndModel (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              LoadSCParameter,
  input  logic                              SingleACQStart,
  input  logic                              ACQDone,
  input  int                                burstLen,
  input  int                                transmitDelay,
  output logic                              MicrorocConfigDone,
  output logic                              DataTransmitDone,
  output logic [sweepAcqPkg::DataWidth-1:0] ParallelData,
  output logic                              ParallelData_en
);

  localparam int ConfigCycles = 8;
  localparam int FirstWordDelay = 30;
  localparam int WordSpacing = 3;
  localparam int BurstGap = 8;

  logic                              configDone = 1'b0;
  logic                              transmitDone = 1'b0;
  logic [sweepAcqPkg::DataWidth-1:0] dataWord = '0;
  logic                              dataValid = 1'b0;
  logic                              loadSeen = 1'b0;
  logic                              acqSeen = 1'b0;
  logic                              doneSeen = 1'b0;
  logic                              acqActive = 1'b0;
  logic [sweepAcqPkg::DataWidth-1:0] nextWord = '0;
  int                                configWait = 0;
  int                                transmitWait = 0;
  int                                waitLeft = 0;
  int                                sentInBurst = 0;

  assign MicrorocConfigDone = configDone;
  assign DataTransmitDone   = transmitDone;
  assign ParallelData       = dataWord;
  assign ParallelData_en    = dataValid;

  // Chip configuration latency
  always @(posedge clk) begin
    loadSeen = LoadSCParameter;
    #1;
    configDone = 1'b0;
    if (!reset_n) begin
      configWait = 0;
    end else if (loadSeen) begin
      configWait = ConfigCycles;
    end else if (configWait > 0) begin
      configWait = configWait - 1;
      if (configWait == 0) begin
        configDone = 1'b1;
      end
    end
  end

  // Fire data in bursts of burstLen words until acquisition stops
  always @(posedge clk) begin
    acqSeen = SingleACQStart;
    #1;
    dataValid = 1'b0;
    if (!reset_n || !acqSeen) begin
      acqActive = 1'b0;
    end else if (!acqActive) begin
      acqActive   = 1'b1;
      waitLeft    = FirstWordDelay;
      sentInBurst = 0;
      nextWord    = sweepAcqPkg::DataWidth'($urandom());
    end else begin
      waitLeft = waitLeft - 1;
      if (waitLeft == 0) begin
        dataWord    = nextWord;
        dataValid   = 1'b1;
        nextWord    = nextWord + sweepAcqPkg::DataWidth'(1);
        sentInBurst = sentInBurst + 1;
        if (sentInBurst == burstLen) begin
          sentInBurst = 0;
          waitLeft    = BurstGap;
        end else begin
          waitLeft = WordSpacing;
        end
      end
    end
  end

  // Transport reply after a programmable delay
  always @(posedge clk) begin
    doneSeen = ACQDone;
    #1;
    transmitDone = 1'b0;
    if (!reset_n) begin
      transmitWait = 0;
    end else if (doneSeen) begin
      transmitWait = transmitDelay;
    end else if (transmitWait > 0) begin
      transmitWait = transmitWait - 1;
      if (transmitWait == 0) begin
        transmitDone = 1'b1;
      end
    end
  end

endmodule

// File: sim/sweepAcqTb.sv
`timescale 1ns/1ns

module sweepAcqTb;

  // Under 200 cycles per point and about 14 points in all
  localparam int TimeoutCycles = 20000;

  logic                                clk;
  logic                                reset_n;
  logic                                resetReq = 1'b0;
  logic                                SweepStart;
  logic [sweepAcqPkg::DacWidth-1:0]    StartDAC0;
  logic [sweepAcqPkg::DacWidth-1:0]    EndDAC0;
  logic [sweepAcqPkg::CountWidth-1:0]  MaxPackageNumber;
  logic                                DataTransmitDone;
  logic                                MicrorocConfigDone;
  logic [sweepAcqPkg::DataWidth-1:0]   ParallelData;
  logic                                ParallelData_en;
  logic                                SingleACQStart;
  logic                                ACQDone;
  logic                                SweepDone;
  logic [sweepAcqPkg::DacWidth-1:0]    OutDAC0;
  logic                                LoadSCParameter;
  logic [sweepAcqPkg::DataWidth-1:0]   SweepACQData;
  logic                                SweepACQData_en;

  int   burstLen = 4;
  int   transmitDelay = 10;
  int   maxWords = 1;
  int   cycleCount = 0;
  int   acceptCount = 0;
  int   doneAt = -1;
  int   transmitCycle = -1;
  int   sweepDoneCount = 0;
  int   gapChecks = 0;
  int   expData = 0;
  logic expEn = 1'b0;
  logic expHeader = 1'b0;
  logic prevAcq = 1'b0;
  logic prevConfigDone = 1'b0;
  int   loadCodes[$];
  int   outStream[$];
  int   sentWords[$];

  tbClock clock_i (
    .resetReq (resetReq),
    .clk      (clk),
    .reset_n  (reset_n)
  );

  frontEndModel frontEnd_i (
    .clk                (clk),
    .reset_n            (reset_n),
    .LoadSCParameter    (LoadSCParameter),
    .SingleACQStart     (SingleACQStart),
    .ACQDone            (ACQDone),
    .burstLen           (burstLen),
    .transmitDelay      (transmitDelay),
    .MicrorocConfigDone (MicrorocConfigDone),
    .DataTransmitDone   (DataTransmitDone),
    .ParallelData       (ParallelData),
    .ParallelData_en    (ParallelData_en)
  );

  sweepAcqTop dut_i (
    .clk                (clk),
    .reset_n            (reset_n),
    .SweepStart         (SweepStart),
    .DataTransmitDone   (DataTransmitDone),
    .StartDAC0          (StartDAC0),
    .EndDAC0            (EndDAC0),
    .MaxPackageNumber   (MaxPackageNumber),
    .ParallelData       (ParallelData),
    .ParallelData_en    (ParallelData_en),
    .MicrorocConfigDone (MicrorocConfigDone),
    .SingleACQStart     (SingleACQStart),
    .ACQDone            (ACQDone),
    .SweepDone          (SweepDone),
    .OutDAC0            (OutDAC0),
    .LoadSCParameter    (LoadSCParameter),
    .SweepACQData       (SweepACQData),
    .SweepACQData_en    (SweepACQData_en)
  );

  task automatic checkValue(input string name, input int actual, input int expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "Check on %s failed", name);
    end
  endtask

  // Marker above the code
  function automatic int headerOf(input int code);
    return (int'(sweepAcqPkg::HeaderMarker) << sweepAcqPkg::HeaderShift) + code;
  endfunction

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("** FAIL **");
      $fatal(1, "Timeout: run did not finish within %0d cycles", TimeoutCycles);
    end
  end

  // Mid-cycle monitor that predicts each output one cycle ahead
  always @(negedge clk) begin
    if (!reset_n) begin
      expEn          = 1'b0;
      expHeader      = 1'b0;
      prevAcq        = 1'b0;
      prevConfigDone = 1'b0;
      acceptCount    = 0;
      doneAt         = -1;
      transmitCycle  = -1;
    end else begin
      checkValue("SweepACQData_en", int'(SweepACQData_en), int'(expEn));
      if (expEn) begin
        if (!expHeader) begin
          checkValue("SweepACQData", int'(SweepACQData), expData);
        end
        outStream.push_back(int'(SweepACQData));
      end
      checkValue("ACQDone", int'(ACQDone), int'(cycleCount == doneAt));
      if (cycleCount == doneAt) begin
        checkValue("SingleACQStart", int'(SingleACQStart), 0);
      end
      if (prevConfigDone) begin
        checkValue("SingleACQStart", int'(SingleACQStart), 1);
      end
      if (DataTransmitDone) begin
        transmitCycle = cycleCount;
      end
      if (LoadSCParameter) begin
        if (loadCodes.size() > 0) begin
          // Later points load only after the transport reply and stepNext
          checkValue("DataTransmitDone seen before LoadSCParameter",
                     int'(transmitCycle >= 0), 1);
          checkValue("LoadSCParameter delay", cycleCount - transmitCycle, 2);
          gapChecks = gapChecks + 1;
        end
        loadCodes.push_back(int'(OutDAC0));
        transmitCycle = -1;
      end
      if (SweepDone) begin
        sweepDoneCount = sweepDoneCount + 1;
        transmitCycle  = -1;
      end

      expEn     = 1'b0;
      expHeader = 1'b0;
      if (SingleACQStart && !prevAcq) begin
        expEn       = 1'b1;
        expHeader   = 1'b1;
        acceptCount = 0;
      end else if (SingleACQStart && ParallelData_en && acceptCount < maxWords) begin
        expEn   = 1'b1;
        expData = int'(ParallelData);
        sentWords.push_back(expData);
        acceptCount = acceptCount + 1;
        if (acceptCount == maxWords) begin
          doneAt = cycleCount + 2;
        end
      end
      prevAcq        = SingleACQStart;
      prevConfigDone = MicrorocConfigDone;
    end
  end

  task automatic runSweep(input int startCode, input int endCode, input int words,
                          input int burst, input int delay);
    @(posedge clk);
    #1;
    StartDAC0        = sweepAcqPkg::DacWidth'(startCode);
    EndDAC0          = sweepAcqPkg::DacWidth'(endCode);
    MaxPackageNumber = sweepAcqPkg::CountWidth'(words);
    maxWords         = words;
    burstLen         = burst;
    transmitDelay    = delay;
    sweepDoneCount   = 0;
    gapChecks        = 0;
    loadCodes.delete();
    outStream.delete();
    sentWords.delete();
    SweepStart = 1'b1;
    @(posedge clk);
    #1;
    SweepStart = 1'b0;
  endtask

  task automatic waitSweepDone();
    while (sweepDoneCount == 0) begin
      @(posedge clk);
    end
    // Room for a stray pulse after the end
    repeat (20) @(posedge clk);
  endtask

  task automatic checkSweep(input int startCode, input int endCode, input int words);
    int step;
    int points;
    int code;
    int base;
    int p;
    int k;
    step   = (endCode < startCode) ? -1 : 1;
    points = (endCode - startCode) * step + 1;
    checkValue("SweepDone count", sweepDoneCount, 1);
    checkValue("LoadSCParameter count", loadCodes.size(), points);
    checkValue("SweepACQData count", outStream.size(), points * (words + 1));
    checkValue("accepted word count", sentWords.size(), points * words);
    for (p = 0; p < points; p++) begin
      code = startCode + p * step;
      base = p * (words + 1);
      checkValue("OutDAC0", loadCodes[p], code);
      checkValue("SweepACQData header", outStream[base], headerOf(code));
      for (k = 0; k < words; k++) begin
        checkValue("SweepACQData", outStream[base + 1 + k], sentWords[p * words + k]);
      end
    end
  endtask

  task automatic checkIdleOutputs();
    checkValue("SingleACQStart", int'(SingleACQStart), 0);
    checkValue("ACQDone", int'(ACQDone), 0);
    checkValue("SweepDone", int'(SweepDone), 0);
    checkValue("LoadSCParameter", int'(LoadSCParameter), 0);
    checkValue("SweepACQData_en", int'(SweepACQData_en), 0);
    checkValue("OutDAC0", int'(OutDAC0), 0);
  endtask

  task automatic upSweepTest();
    runSweep(475, 477, 4, 6, 10);
    waitSweepDone();
    checkSweep(475, 477, 4);
  endtask

  task automatic downSweepTest();
    runSweep(12, 10, 4, 6, 10);
    waitSweepDone();
    checkSweep(12, 10, 4);
  endtask

  task automatic singlePointTest();
    runSweep(300, 300, 2, 4, 5);
    waitSweepDone();
    checkSweep(300, 300, 2);
  endtask

  // Limit above the burst length and a long transport reply
  task automatic timingTest();
    runSweep(40, 42, 5, 3, 50);
    waitSweepDone();
    checkSweep(40, 42, 5);
    checkValue("checked load gaps", gapChecks, 2);
  endtask

  task automatic busyStartTest();
    runSweep(100, 102, 3, 4, 12);
    while (loadCodes.size() < 2) begin
      @(posedge clk);
    end
    #1;
    StartDAC0  = sweepAcqPkg::DacWidth'(700);
    SweepStart = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    SweepStart = 1'b0;
    waitSweepDone();
    checkSweep(100, 102, 3);

    // Reset in the middle of an acquisition
    runSweep(200, 201, 3, 4, 12);
    while (!SingleACQStart) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    resetReq = 1'b1;
    #1;
    checkIdleOutputs();
    repeat (8) @(posedge clk);
    #1;
    resetReq = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    checkIdleOutputs();
  endtask

  initial begin
    SweepStart       = 1'b0;
    StartDAC0        = '0;
    EndDAC0          = '0;
    MaxPackageNumber = '0;
    void'($urandom(12));
    wait (reset_n === 1'b1);
    @(negedge clk);
    checkIdleOutputs();

    upSweepTest();
    downSweepTest();
    singlePointTest();
    timingTest();
    busyStartTest();

    $display("** PASS **");
    $finish;
  end

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ns

module tbClock (
  input  logic resetReq,
  output logic clk,
  output logic reset_n
);

  logic clkReg = 1'b0;
  logic powerOnDone = 1'b0;

  // 8 ns period
  always #4 clkReg = ~clkReg;

  assign clk = clkReg;

  initial begin
    repeat (8) @(posedge clkReg);
    #1;
    powerOnDone = 1'b1;
  end

  // Testbench can pull reset again mid-run
  assign reset_n = powerOnDone && !resetReq;

endmodule

// File: src/dacStepper.sv
`timescale 1ns/1ns

module dacStepper (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             stepLoad,
  input  logic                             stepNext,
  input  logic [sweepAcqPkg::DacWidth-1:0] StartDAC0,
  input  logic [sweepAcqPkg::DacWidth-1:0] EndDAC0,
  output logic [sweepAcqPkg::DacWidth-1:0] dacCode,
  output logic                             lastPoint
);

  logic [sweepAcqPkg::DacWidth-1:0] endCode;
  logic                             stepDown;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dacCode  <= '0;
      endCode  <= '0;
      stepDown <= 1'b0;
    end else if (stepLoad) begin
      dacCode  <= StartDAC0;
      endCode  <= EndDAC0;
      stepDown <= EndDAC0 < StartDAC0;
    end else if (stepNext && !lastPoint) begin
      // One code toward the end
      if (stepDown) begin
        dacCode <= dacCode - 1'b1;
      end else begin
        dacCode <= dacCode + 1'b1;
      end
    end
  end

  // Start equal to end gives a single point
  assign lastPoint = (dacCode == endCode);

endmodule

// File: src/packageCounter.sv
`timescale 1ns/1ns

module packageCounter (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               countClear,
  input  logic                               SingleACQStart,
  input  logic                               ParallelData_en,
  input  logic [sweepAcqPkg::CountWidth-1:0] MaxPackageNumber,
  output logic                               wordAccept,
  output logic                               countFull
);

  logic [sweepAcqPkg::CountWidth-1:0] wordCount;
  logic [sweepAcqPkg::CountWidth-1:0] countLimit;

  // Old count is still visible during the clear cycle, so mask it
  assign countFull = !countClear && (wordCount == countLimit);

  // Clear cycle belongs to the header slot
  assign wordAccept = ParallelData_en && SingleACQStart && !countFull && !countClear;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wordCount  <= '0;
      countLimit <= '0;
    end else if (countClear) begin
      wordCount  <= '0;
      countLimit <= MaxPackageNumber;
    end else if (wordAccept) begin
      wordCount <= wordCount + 1'b1;
    end
  end

endmodule

// File: src/sweepAcqPkg.sv
package sweepAcqPkg;

  // DAC0 code width of the readout chip
  localparam int DacWidth = 10;

  // Fire data word and output stream word
  localparam int DataWidth = 16;

  // MaxPackageNumber and the per-point word counter
  localparam int CountWidth = 16;

  // Upper bits of a per-point header word
  localparam logic [5:0] HeaderMarker = 6'b101010;

  // Marker sits right above the DAC code
  localparam int HeaderShift = DacWidth;

endpackage

// File: src/sweepAcqTop.sv
`timescale 1ns/1ns

module sweepAcqTop (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic                                  SweepStart,
  input  logic                                  DataTransmitDone,
  input  logic [sweepAcqPkg::DacWidth-1:0]      StartDAC0,
  input  logic [sweepAcqPkg::DacWidth-1:0]      EndDAC0,
  input  logic [sweepAcqPkg::CountWidth-1:0]    MaxPackageNumber,
  input  logic [sweepAcqPkg::DataWidth-1:0]     ParallelData,
  input  logic                                  ParallelData_en,
  input  logic                                  MicrorocConfigDone,
  output logic                                  SingleACQStart,
  output logic                                  ACQDone,
  output logic                                  SweepDone,
  output logic [sweepAcqPkg::DacWidth-1:0]      OutDAC0,
  output logic                                  LoadSCParameter,
  output logic [sweepAcqPkg::DataWidth-1:0]     SweepACQData,
  output logic                                  SweepACQData_en
);

  logic stepLoad;
  logic stepNext;
  logic countClear;
  logic lastPoint;
  logic wordAccept;
  logic countFull;

  sweepControl control_i (
    .clk                (clk),
    .reset_n            (reset_n),
    .SweepStart         (SweepStart),
    .MicrorocConfigDone (MicrorocConfigDone),
    .DataTransmitDone   (DataTransmitDone),
    .countFull          (countFull),
    .lastPoint          (lastPoint),
    .stepLoad           (stepLoad),
    .stepNext           (stepNext),
    .countClear         (countClear),
    .LoadSCParameter    (LoadSCParameter),
    .SingleACQStart     (SingleACQStart),
    .ACQDone            (ACQDone),
    .SweepDone          (SweepDone)
  );

  // Current DAC code goes straight out as OutDAC0
  dacStepper stepper_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .stepLoad  (stepLoad),
    .stepNext  (stepNext),
    .StartDAC0 (StartDAC0),
    .EndDAC0   (EndDAC0),
    .dacCode   (OutDAC0),
    .lastPoint (lastPoint)
  );

  packageCounter counter_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .countClear       (countClear),
    .SingleACQStart   (SingleACQStart),
    .ParallelData_en  (ParallelData_en),
    .MaxPackageNumber (MaxPackageNumber),
    .wordAccept       (wordAccept),
    .countFull        (countFull)
  );

  sweepDataPath dataPath_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .SingleACQStart  (SingleACQStart),
    .dacCode         (OutDAC0),
    .wordAccept      (wordAccept),
    .ParallelData    (ParallelData),
    .SweepACQData    (SweepACQData),
    .SweepACQData_en (SweepACQData_en)
  );

endmodule

// File: src/sweepControl.sv
`timescale 1ns/1ns

module sweepControl (
  input  logic clk,
  input  logic reset_n,
  input  logic SweepStart,
  input  logic MicrorocConfigDone,
  input  logic DataTransmitDone,
  input  logic countFull,
  input  logic lastPoint,
  output logic stepLoad,
  output logic stepNext,
  output logic countClear,
  output logic LoadSCParameter,
  output logic SingleACQStart,
  output logic ACQDone,
  output logic SweepDone
);

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    CONFIG,
    ACQ,
    TRANSMIT,
    NEXT
  } stateT;

  stateT state;

  // Start code is loaded in the cycle the sweep is accepted
  assign stepLoad = (state == IDLE) && SweepStart;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state           <= IDLE;
      stepNext        <= 1'b0;
      countClear      <= 1'b0;
      LoadSCParameter <= 1'b0;
      SingleACQStart  <= 1'b0;
      ACQDone         <= 1'b0;
      SweepDone       <= 1'b0;
    end else begin
      // Pulses last one cycle unless set below
      stepNext        <= 1'b0;
      countClear      <= 1'b0;
      LoadSCParameter <= 1'b0;
      ACQDone         <= 1'b0;
      SweepDone       <= 1'b0;

      case (state)
        IDLE: begin
          if (stepLoad) begin
            state <= LOAD;
          end
        end

        // dacCode holds the start code here
        LOAD: begin
          LoadSCParameter <= 1'b1;
          state           <= CONFIG;
        end

        CONFIG: begin
          if (MicrorocConfigDone) begin
            SingleACQStart <= 1'b1;
            countClear     <= 1'b1;
            state          <= ACQ;
          end
        end

        ACQ: begin
          if (countFull) begin
            SingleACQStart <= 1'b0;
            ACQDone        <= 1'b1;
            state          <= TRANSMIT;
          end
        end

        TRANSMIT: begin
          if (DataTransmitDone) begin
            if (lastPoint) begin
              SweepDone <= 1'b1;
              state     <= IDLE;
            end else begin
              stepNext <= 1'b1;
              state    <= NEXT;
            end
          end
        end

        // Stepper moves at the end of this cycle, so the new code
        // lines up with the load pulse
        NEXT: begin
          LoadSCParameter <= 1'b1;
          state           <= CONFIG;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: src/sweepDataPath.sv
`timescale 1ns/1ns

module sweepDataPath (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              SingleACQStart,
  input  logic [sweepAcqPkg::DacWidth-1:0]  dacCode,
  input  logic                              wordAccept,
  input  logic [sweepAcqPkg::DataWidth-1:0] ParallelData,
  output logic [sweepAcqPkg::DataWidth-1:0] SweepACQData,
  output logic                              SweepACQData_en
);

  logic                              acqStartDly;
  logic                              acqRise;
  logic [sweepAcqPkg::DataWidth-1:0] headerWord;

  assign acqRise = SingleACQStart && !acqStartDly;

  // Marker on top, DAC code in the low bits
  assign headerWord = (sweepAcqPkg::DataWidth'(sweepAcqPkg::HeaderMarker)
                       << sweepAcqPkg::HeaderShift)
                      | sweepAcqPkg::DataWidth'(dacCode);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      acqStartDly     <= 1'b0;
      SweepACQData_en <= 1'b0;
    end else begin
      acqStartDly     <= SingleACQStart;
      SweepACQData_en <= acqRise || wordAccept;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (acqRise) begin
      SweepACQData <= headerWord;
    end else if (wordAccept) begin
      SweepACQData <= ParallelData;
    end
  end

endmodule
